//--- project.f
+incdir+.
cpu_pkg.sv
stage_if.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
cpuTop.sv
cpu_asserts.sv
cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- cpuTb.sv
`default_nettype none

`include "cpu_params.svh"

module cpuTb import cpuPkg::*; ();

	localparam int clkPeriod = 8;
	localparam int driveDly = 1;
	localparam int numInstr = 2000;
	localparam logic [31:0] seed = 32'h484a_0e2a;
	localparam int timeout = (numInstr + 3 + 50) * clkPeriod;    // run length plus margin

	logic     clk;
	logic     arstN;
	word_t    inst;
	word_t    pc;
	logic     regWrEn;
	regAddr_t regWrAddr;
	word_t    regWrData;
	logic     memWrEn;
	word_t    memAddr;
	word_t    memWrData;

	// reference model state
	word_t modelRegs [32];
	word_t modelMem [`DMEM_WORDS];
	word_t modelPc;
	logic  modelRun;       // writes blocked in the first cycle after reset
	int    errors;

	cpuTop uut (
		.clk       (clk),
		.arstN     (arstN),
		.inst      (inst),
		.pc        (pc),
		.regWrEn   (regWrEn),
		.regWrAddr (regWrAddr),
		.regWrData (regWrData),
		.memWrEn   (memWrEn),
		.memAddr   (memAddr),
		.memWrData (memWrData)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(timeout);
		$display("watchdog expired after %0d time units, the run did not finish", timeout);
		$display("*** FAILED ***");
		$fatal(1, "watchdog timeout");
	end

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// random kept instruction, jr only through an aligned register
	function automatic word_t randomInst();
		word_t       r;
		word_t       r2;
		regAddr_t    rs;
		regAddr_t    rt;
		regAddr_t    rd;
		imm_t        imm;
		imm_t        memImm;
		int unsigned kind;
		r = $urandom();
		r2 = $urandom();
		kind = $urandom_range(0, 13);
		rs = r[25:21];
		rt = r[20:16];
		rd = r[15:11];
		imm = r[15:0];
		memImm = {8'd0, r2[7:0]};    // small offsets reach all 64 words
		if (r[31:30] == 2'b00)
			rt = rs;    // equal operands for taken beq
		case (kind)
			0: randomInst = {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADD};
			1: randomInst = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SUB};
			2: randomInst = {OP_RTYPE, rs, rt, rd, 5'd0, FN_AND};
			3: randomInst = {OP_RTYPE, rs, rt, rd, 5'd0, FN_OR};
			4: randomInst = {OP_RTYPE, rs, rt, rd, 5'd0, FN_SLT};
			5:
			begin
				if (modelRegs[rs][1:0] != 2'b00)
					rs = (modelRegs[31][1:0] == 2'b00) ? 5'd31 : 5'd0;
				randomInst = {OP_RTYPE, rs, 5'd0, 5'd0, 5'd0, FN_JR};
			end
			6: randomInst = {OP_ADDI, rs, rt, imm};
			7: randomInst = {OP_SLTI, rs, rt, imm};
			8: randomInst = {OP_LW, (r2[8] ? 5'd0 : rs), rt, memImm};
			9: randomInst = {OP_SW, (r2[8] ? 5'd0 : rs), rt, memImm};
			10: randomInst = {OP_BEQ, rs, rt, imm};
			11: randomInst = {OP_BNE, rs, rt, imm};
			12: randomInst = {OP_J, r[25:0]};
			default: randomInst = {OP_JAL, r[25:0]};
		endcase
	endfunction

	task automatic executeAndCompare(input word_t instr, input int n);
		logic [5:0] op;
		logic [5:0] fn;
		regAddr_t   expAddr;
		word_t      a;
		word_t      b;
		word_t      sImm;
		word_t      seq;
		word_t      nPc;
		word_t      addr;
		word_t      expData;
		logic       expWr;
		logic       expMemWr;
		logic       isMem;
		string      tag;
		op = instr[31:26];
		fn = instr[5:0];
		a = modelRegs[instr[25:21]];    // entry 0 is never written
		b = modelRegs[instr[20:16]];
		sImm = {{16{instr[15]}}, instr[15:0]};
		seq = modelPc + 32'd4;
		addr = a + sImm;
		nPc = seq;
		expWr = 1'b0;
		expMemWr = 1'b0;
		isMem = 1'b0;
		expAddr = instr[20:16];
		expData = '0;
		case (op)
			OP_RTYPE:
			begin
				expWr = 1'b1;
				expAddr = instr[15:11];
				case (fn)
					FN_ADD: expData = a + b;
					FN_SUB: expData = a - b;
					FN_AND: expData = a & b;
					FN_OR:  expData = a | b;
					FN_SLT: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:
					begin
						expWr = 1'b0;    // jr
						nPc = a;
					end
				endcase
			end
			OP_ADDI:
			begin
				expWr = 1'b1;
				expData = a + sImm;
			end
			OP_SLTI:
			begin
				expWr = 1'b1;
				expData = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			end
			OP_LW:
			begin
				isMem = 1'b1;
				expWr = 1'b1;
				expData = modelMem[addr[7:2]];
			end
			OP_SW:
			begin
				isMem = 1'b1;
				expMemWr = 1'b1;
			end
			OP_BEQ: nPc = (a == b) ? seq + (sImm << 2) : seq;
			OP_BNE: nPc = (a != b) ? seq + (sImm << 2) : seq;
			OP_J:   nPc = {seq[31:28], instr[25:0], 2'b00};
			default:
			begin
				nPc = {seq[31:28], instr[25:0], 2'b00};    // jal
				expWr = 1'b1;
				expAddr = 5'd31;
				expData = seq;
			end
		endcase
		if (!modelRun)
		begin
			expWr = 1'b0;
			expMemWr = 1'b0;
		end
		tag = $sformatf("instr %0d (%h)", n, instr);
		checkValue({tag, " pc"}, modelPc, pc);
		checkValue({tag, " regWrEn"}, word_t'(expWr), word_t'(regWrEn));
		if (expWr)
		begin
			checkValue({tag, " regWrAddr"}, word_t'(expAddr), word_t'(regWrAddr));
			checkValue({tag, " regWrData"}, expData, regWrData);
		end
		checkValue({tag, " memWrEn"}, word_t'(expMemWr), word_t'(memWrEn));
		if (isMem)
			checkValue({tag, " memAddr"}, addr, memAddr);
		if (expMemWr)
			checkValue({tag, " memWrData"}, b, memWrData);
		// state moves as the DUT does at the next edge
		if (expWr && expAddr != 5'd0)
			modelRegs[expAddr] = expData;
		if (expMemWr)
			modelMem[addr[7:2]] = b;
		modelPc = nPc;
		modelRun = 1'b1;
	endtask

	initial
	begin
		word_t instr;
		void'($urandom(seed));
		arstN = 1'b0;
		inst = {OP_ADDI, 5'd0, 5'd1, 16'h0001};    // would write r1 if not held
		errors = 0;
		modelPc = `RESET_PC;
		modelRun = 1'b0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			modelMem[i] = '0;
		@(posedge clk);
		@(negedge clk);
		checkValue("reset pc", `RESET_PC, pc);
		checkValue("reset regWrEn", '0, word_t'(regWrEn));
		@(posedge clk);
		#(driveDly);
		inst = {OP_SW, 5'd0, 5'd1, 16'h0004};    // would write memory if not held
		@(negedge clk);
		checkValue("reset memWrEn", '0, word_t'(memWrEn));
		@(posedge clk);
		#(driveDly);
		arstN = 1'b1;
		for (int n = 0; n < numInstr; n++)
		begin
			instr = randomInst();
			inst = instr;
			@(negedge clk);    // outputs settled, edge still ahead
			executeAndCompare(instr, n);
			@(posedge clk);
			#(driveDly);
		end
		if (errors == 0)
		begin
			$display("*** PASSED ***");
			$finish;
		end
		else
		begin
			$display("*** FAILED ***");
			$fatal(1, "%0d checks failed", errors);
		end
	end

endmodule

`default_nettype wire

//--- cpu_asserts.sv
`default_nettype none

module cpuAsserts import cpuPkg::*;
(
	input logic  clk,
	input logic  arstN,
	input word_t pc,
	input logic  regWrEn,
	input logic  memWrEn
);

	// fetch addresses are whole words
	pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	oneWriteOnly: assert property (@(posedge clk) disable iff (!arstN) !(regWrEn && memWrEn))
		else $error("register and memory write enables high together");

	quietInReset: assert property (@(posedge clk) !arstN |-> (!regWrEn && !memWrEn))
		else $error("write enable high during reset");

endmodule

bind cpuTop cpuAsserts uAsserts (
	.clk     (clk),
	.arstN   (arstN),
	.pc      (pc),
	.regWrEn (regWrEn),
	.memWrEn (memWrEn)
);

`default_nettype wire

//--- cpuTop.sv
`default_nettype none

module cpuTop import cpuPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  word_t    inst,        // from instruction memory, same cycle
	output word_t    pc,
	output logic     regWrEn,
	output regAddr_t regWrAddr,
	output word_t    regWrData,
	output logic     memWrEn,
	output word_t    memAddr,
	output word_t    memWrData
);

	word_t pcPlus4;
	word_t nextPc;

	decodeBus decIf ();
	execBus   exeIf ();

	fetchStage uFetch (
		.clk     (clk),
		.arstN   (arstN),
		.nextPc  (nextPc),
		.pc      (pc),
		.pcPlus4 (pcPlus4)
	);

	// writeback loops back into the register file
	decodeStage uDecode (
		.clk     (clk),
		.arstN   (arstN),
		.inst    (inst),
		.pcPlus4 (pcPlus4),
		.wbEn    (regWrEn),
		.wbAddr  (regWrAddr),
		.wbData  (regWrData),
		.dec     (decIf.src)
	);

	executeStage uExecute (
		.dec    (decIf.dst),
		.exe    (exeIf.src),
		.nextPc (nextPc)
	);

	memWbStage uMemWb (
		.clk       (clk),
		.arstN     (arstN),
		.exe       (exeIf.dst),
		.wbEn      (regWrEn),
		.wbAddr    (regWrAddr),
		.wbData    (regWrData),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memWrEn   (memWrEn)
	);

endmodule

`default_nettype wire

//--- memWbStage.sv
`default_nettype none

`include "cpu_params.svh"

module memWbStage import cpuPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	execBus.dst      exe,
	output logic     wbEn,
	output regAddr_t wbAddr,
	output word_t    wbData,
	output word_t    memAddr,
	output word_t    memWrData,
	output logic     memWrEn
);

	localparam int idxW = $clog2(`DMEM_WORDS);

	word_t            dmem [`DMEM_WORDS];
	logic [idxW-1:0]  dIdx;      // word index, byte offset dropped
	word_t            rdData;

	assign dIdx = exe.aluResult[idxW+1:2];
	assign rdData = dmem[dIdx];    // asynchronous read

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (exe.memWrEn)
			dmem[dIdx] <= exe.storeData;
	end

	always_comb
	begin
		case (exe.wbSel)
			WB_MEM:  wbData = rdData;
			WB_LINK: wbData = exe.pcPlus4;    // jal return address
			default: wbData = exe.aluResult;
		endcase
	end

	assign wbEn = exe.regWrEn;
	assign wbAddr = exe.dstAddr;
	assign memAddr = exe.aluResult;
	assign memWrData = exe.storeData;
	assign memWrEn = exe.memWrEn;

endmodule

`default_nettype wire

//--- executeStage.sv
`default_nettype none

module executeStage import cpuPkg::*;
(
	decodeBus.dst dec,
	execBus.src   exe,
	output word_t nextPc
);

	word_t aluB;
	word_t aluRes;
	logic  zero;
	logic  taken;
	word_t brTarget;
	word_t jumpTarget;

	assign aluB = dec.aluSrc ? dec.immExt : dec.rtData;

	always_comb
	begin
		case (dec.aluOp)
			ALU_ADD: aluRes = dec.rsData + aluB;
			ALU_SUB: aluRes = dec.rsData - aluB;
			ALU_AND: aluRes = dec.rsData & aluB;
			ALU_OR:  aluRes = dec.rsData | aluB;
			ALU_SLT: aluRes = {31'd0, $signed(dec.rsData) < $signed(aluB)};
			default: aluRes = '0;
		endcase
	end

	assign zero = (aluRes == '0);
	assign taken = (dec.branch & zero) | (dec.branchNe & ~zero);
	assign brTarget = dec.pcPlus4 + (dec.immExt << 2);
	assign jumpTarget = {dec.pcPlus4[31:28], dec.jumpIdx, 2'b00};

	always_comb
	begin
		case (dec.pcSel)
			PC_JUMP: nextPc = jumpTarget;
			PC_REG:  nextPc = dec.rsData;    // jr
			default: nextPc = taken ? brTarget : dec.pcPlus4;
		endcase
	end

	always_comb
	begin
		case (dec.regDst)
			RD_RD:   exe.dstAddr = dec.rdAddr;
			RD_LINK: exe.dstAddr = 5'd31;
			default: exe.dstAddr = dec.rtAddr;
		endcase
	end

	assign exe.regWrEn = (dec.wbSel != WB_LINK) || (dec.regDst == RD_LINK);
	assign exe.aluResult = aluRes;
	assign exe.storeData = dec.rtData;
	assign exe.memWrEn = dec.memWrEn;
	assign exe.wbSel = dec.wbSel;
	assign exe.pcPlus4 = dec.pcPlus4;

endmodule

`default_nettype wire

//--- decodeStage.sv
`default_nettype none

module decodeStage import cpuPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  word_t    inst,
	input  word_t    pcPlus4,
	input  logic     wbEn,
	input  regAddr_t wbAddr,
	input  word_t    wbData,
	decodeBus.src    dec
);

	opcode_t  opcode;
	funct_t   funct;
	regAddr_t rsAddr;
	imm_t     imm;
	word_t    regFile [32];
	logic     run;          // low until the first edge after reset

	aluOp_t  aluOpC;
	logic    aluSrcC;
	logic    branchC;
	logic    branchNeC;
	pcSel_t  pcSelC;
	logic    memWrC;
	wbSel_t  wbSelC;
	regDst_t regDstC;
	logic    noWrite;       // instruction has no register result

	assign opcode = opcode_t'(inst[31:26]);
	assign funct = funct_t'(inst[5:0]);
	assign rsAddr = inst[25:21];
	assign imm = inst[15:0];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	// main control and ALU control in one table
	always_comb
	begin
		aluOpC = ALU_ADD;
		aluSrcC = 1'b0;
		branchC = 1'b0;
		branchNeC = 1'b0;
		pcSelC = PC_SEQ;
		memWrC = 1'b0;
		wbSelC = WB_ALU;
		regDstC = RD_RT;
		noWrite = 1'b0;
		case (opcode)
			OP_RTYPE:
			begin
				regDstC = RD_RD;
				case (funct)
					FN_ADD: aluOpC = ALU_ADD;
					FN_SUB: aluOpC = ALU_SUB;
					FN_AND: aluOpC = ALU_AND;
					FN_OR:  aluOpC = ALU_OR;
					FN_SLT: aluOpC = ALU_SLT;
					FN_JR:
					begin
						pcSelC = PC_REG;
						noWrite = 1'b1;
					end
					default: noWrite = 1'b1;
				endcase
			end
			OP_ADDI: aluSrcC = 1'b1;
			OP_SLTI:
			begin
				aluSrcC = 1'b1;
				aluOpC = ALU_SLT;
			end
			OP_LW:
			begin
				aluSrcC = 1'b1;
				wbSelC = WB_MEM;
			end
			OP_SW:
			begin
				aluSrcC = 1'b1;
				memWrC = 1'b1;
				noWrite = 1'b1;
			end
			OP_BEQ:
			begin
				aluOpC = ALU_SUB;    // zero flag gives equality
				branchC = 1'b1;
				noWrite = 1'b1;
			end
			OP_BNE:
			begin
				aluOpC = ALU_SUB;
				branchNeC = 1'b1;
				noWrite = 1'b1;
			end
			OP_J:
			begin
				pcSelC = PC_JUMP;
				noWrite = 1'b1;
			end
			OP_JAL:
			begin
				pcSelC = PC_JUMP;
				wbSelC = WB_LINK;
				regDstC = RD_LINK;
			end
			default: noWrite = 1'b1;
		endcase
	end

	// register file, entry 0 is never written
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				regFile[i] <= '0;
		end
		else if (wbEn && wbAddr != '0)
			regFile[wbAddr] <= wbData;
	end

	assign dec.rsData = (rsAddr == '0) ? '0 : regFile[rsAddr];
	assign dec.rtData = (inst[20:16] == '0) ? '0 : regFile[inst[20:16]];
	assign dec.immExt = {{16{imm[15]}}, imm};
	assign dec.jumpIdx = inst[25:0];
	assign dec.aluOp = aluOpC;
	assign dec.aluSrc = aluSrcC;
	assign dec.branch = branchC;
	assign dec.branchNe = branchNeC;
	assign dec.pcSel = pcSelC;
	assign dec.rtAddr = inst[20:16];
	assign dec.rdAddr = inst[15:11];
	assign dec.pcPlus4 = pcPlus4;

	// link select without the link register tells execute there is no writeback
	assign dec.memWrEn = memWrC & run;
	assign dec.wbSel = (noWrite || !run) ? WB_LINK : wbSelC;
	assign dec.regDst = (noWrite || !run) ? RD_RT : regDstC;

endmodule

`default_nettype wire

//--- fetchStage.sv
`default_nettype none

`include "cpu_params.svh"

module fetchStage import cpuPkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  word_t nextPc,    // resolved in execute
	output word_t pc,
	output word_t pcPlus4
);

	word_t pcReg;

	// one instruction per cycle, so pc simply follows nextPc
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			pcReg <= `RESET_PC;
		else
			pcReg <= nextPc;
	end

	assign pc = pcReg;
	assign pcPlus4 = pcReg + 32'd4;    // sequential address

endmodule

`default_nettype wire

//--- stage_if.sv
`default_nettype none

// decoded instruction, decode to execute
interface decodeBus import cpuPkg::*; ();
	word_t    rsData;
	word_t    rtData;
	word_t    immExt;      // sign-extended immediate
	logic [25:0] jumpIdx;
	aluOp_t   aluOp;
	logic     aluSrc;      // 1 selects the immediate
	logic     branch;      // beq
	logic     branchNe;    // bne
	pcSel_t   pcSel;
	logic     memWrEn;
	wbSel_t   wbSel;
	regDst_t  regDst;
	regAddr_t rtAddr;
	regAddr_t rdAddr;
	word_t    pcPlus4;

	modport src (output rsData, rtData, immExt, jumpIdx, aluOp, aluSrc, branch, branchNe,
		pcSel, memWrEn, wbSel, regDst, rtAddr, rdAddr, pcPlus4);
	modport dst (input rsData, rtData, immExt, jumpIdx, aluOp, aluSrc, branch, branchNe,
		pcSel, memWrEn, wbSel, regDst, rtAddr, rdAddr, pcPlus4);
endinterface

// execute results, execute to memory-writeback
interface execBus import cpuPkg::*; ();
	word_t    aluResult;   // also the data memory address
	word_t    storeData;
	logic     memWrEn;
	wbSel_t   wbSel;
	regAddr_t dstAddr;
	logic     regWrEn;
	word_t    pcPlus4;     // link value for jal

	modport src (output aluResult, storeData, memWrEn, wbSel, dstAddr, regWrEn, pcPlus4);
	modport dst (input aluResult, storeData, memWrEn, wbSel, dstAddr, regWrEn, pcPlus4);
endinterface

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t;    // data, address and instruction
	typedef logic [4:0]  regAddr_t;
	typedef logic [15:0] imm_t;     // raw immediate field

	// opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// funct field of R-type, inst[5:0]
	typedef enum logic [5:0] {
		FN_JR  = 6'h08,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_t;

	// encodings follow the three-way muxes of the datapath
	typedef enum logic [1:0] {RD_RD, RD_RT, RD_LINK} regDst_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSel_t;
	typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_REG} pcSel_t;

endpackage

`default_nettype wire

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data memory depth in 32-bit words
`define DMEM_WORDS 64

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
